// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= dcache_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := dcache_pkg.sv dcache_sram.sv dcache_repl.sv dcache_merge.sv \
        dcache_ctrl.sv dcache_top.sv tb_dcache.sv
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// File: dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                                         clk,
    input  logic                                         rst,
    // cpu side
    input  logic                                         req_i,
    input  logic                                         we_i,
    input  dcache_pkg::addr_t                            addr_i,
    input  dcache_pkg::word_t                            wdata_i,
    input  dcache_pkg::strb_t                            wstrb_i,
    output logic                                         ready_o,
    output logic                                         resp_valid_o,
    output logic                                         hit_o,
    output dcache_pkg::word_t                            rdata_o,
    // memory side
    output logic                                         mem_ren_o,
    output dcache_pkg::addr_t                            mem_araddr_o,
    input  logic                                         mem_rvalid_i,
    input  dcache_pkg::line_t                            mem_rdata_i,
    output logic                                         mem_wen_o,
    output dcache_pkg::addr_t                            mem_awaddr_o,
    output dcache_pkg::line_t                            mem_wdata_o,
    // tag and line arrays
    output dcache_pkg::index_t                           ram_index_o,
    output logic [dcache_pkg::num_ways-1:0]              tag_we_o,
    output dcache_pkg::tag_entry_t                       tag_wentry_o,
    input  dcache_pkg::tag_entry_t [dcache_pkg::num_ways-1:0] tag_rentry_i,
    output logic [dcache_pkg::num_ways-1:0]              line_we_o,
    output dcache_pkg::line_t                            line_wentry_o,
    input  dcache_pkg::line_t [dcache_pkg::num_ways-1:0] line_rentry_i,
    // replacement tracker
    output logic                                         touch_o,
    output logic                                         touch_way_o,
    output logic                                         fill_o,
    output logic                                         set_dirty_o,
    input  logic                                         victim_way_i,
    input  logic                                         victim_valid_i,
    input  logic                                         victim_dirty_i,
    input  logic [dcache_pkg::num_ways-1:0]              way_valid_i,
    // merge unit
    output dcache_pkg::line_t                            merge_line_o,
    output logic [2:0]                                   merge_word_sel_o,
    output dcache_pkg::word_t                            merge_wdata_o,
    output dcache_pkg::strb_t                            merge_wstrb_o,
    output logic                                         merge_write_o,
    input  dcache_pkg::word_t                            merge_word_i,
    input  dcache_pkg::line_t                            merge_line_i
);

    import dcache_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_refill
    } state_t;

    state_t state_q;
    state_t state_d;

    addr_t  cap_addr_q;
    logic   cap_we_q;
    word_t  cap_wdata_q;
    strb_t  cap_wstrb_q;

    tag_t   cap_tag;
    index_t cap_index;

    logic [num_ways-1:0] way_hit;
    logic       any_hit;
    logic       hit_way;
    logic       in_lookup;
    logic       in_refill;
    logic       refill_done;
    tag_entry_t victim_entry;

    ////////////////////////////////////////////////////////////
    // request capture and fsm
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state_q == st_idle && req_i) begin
            cap_addr_q  <= addr_i;
            cap_we_q    <= we_i;
            cap_wdata_q <= wdata_i;
            cap_wstrb_q <= wstrb_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle:   if (req_i) state_d = st_lookup;
            st_lookup: state_d = any_hit ? st_idle : st_refill;
            st_refill: if (mem_rvalid_i) state_d = st_idle;
            default:   state_d = st_idle;
        endcase
    end

    assign in_lookup   = (state_q == st_lookup);
    assign in_refill   = (state_q == st_refill);
    assign refill_done = in_refill && mem_rvalid_i;

    assign cap_tag   = cap_addr_q[offset_w+index_w +: tag_w];
    assign cap_index = cap_addr_q[offset_w +: index_w];

    // arrays read ahead from the live address while idle
    assign ram_index_o = (state_q == st_idle) ? addr_i[offset_w +: index_w] : cap_index;

    ////////////////////////////////////////////////////////////
    // hit detection
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            way_hit[w] = way_valid_i[w] && tag_rentry_i[w].valid
                         && (tag_rentry_i[w].tag == cap_tag);
        end
    end

    assign any_hit      = |way_hit;
    assign hit_way      = way_hit[1];
    assign victim_entry = tag_rentry_i[victim_way_i];

    // cpu response
    assign ready_o      = (state_q == st_idle);
    assign hit_o        = in_lookup && any_hit;
    assign resp_valid_o = hit_o || refill_done;
    assign rdata_o      = merge_word_i;

    // miss issues the refill, plus the write-back of a dirty victim
    assign mem_ren_o    = in_lookup && !any_hit;
    assign mem_araddr_o = {cap_tag, cap_index, {offset_w{1'b0}}};
    assign mem_wen_o    = mem_ren_o && victim_valid_i && victim_dirty_i;
    assign mem_awaddr_o = {victim_entry.tag, cap_index, {offset_w{1'b0}}};
    assign mem_wdata_o  = line_rentry_i[victim_way_i];

    // merge source is the memory line on refill, the hit line otherwise
    assign merge_line_o     = in_refill ? mem_rdata_i : line_rentry_i[hit_way];
    assign merge_word_sel_o = cap_addr_q[offset_w-1:2];
    assign merge_wdata_o    = cap_wdata_q;
    assign merge_wstrb_o    = cap_wstrb_q;
    assign merge_write_o    = cap_we_q;

    ////////////////////////////////////////////////////////////
    // array and tracker updates
    ////////////////////////////////////////////////////////////

    always_comb begin
        tag_we_o  = '0;
        line_we_o = '0;
        if (hit_o && cap_we_q) begin
            line_we_o[hit_way] = 1'b1;
        end
        if (refill_done) begin
            tag_we_o[victim_way_i]  = 1'b1;
            line_we_o[victim_way_i] = 1'b1;
        end
    end

    assign tag_wentry_o  = '{valid: 1'b1, tag: cap_tag};
    assign line_wentry_o = merge_line_i;

    assign touch_o     = hit_o || refill_done;
    assign touch_way_o = in_lookup ? hit_way : victim_way_i;
    assign fill_o      = refill_done;
    assign set_dirty_o = cap_we_q;

endmodule

// File: dcache_merge.sv
`timescale 1ns/1ps

module dcache_merge (
    input  dcache_pkg::line_t line_i,
    input  logic [2:0]        word_sel_i,
    input  dcache_pkg::word_t wdata_i,
    input  dcache_pkg::strb_t wstrb_i,
    input  logic              write_i,
    output dcache_pkg::word_t word_o,
    output dcache_pkg::line_t line_o
);

    import dcache_pkg::*;

    word_t old_word;
    word_t new_word;

    assign old_word = line_i[word_sel_i];

    // byte lanes of the selected word
    always_comb begin
        new_word = old_word;
        if (write_i) begin
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (wstrb_i[b]) begin
                    new_word[8*b +: 8] = wdata_i[8*b +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // line rebuild
    ////////////////////////////////////////////////////////////

    always_comb begin
        line_o = line_i;
        line_o[word_sel_i] = new_word;
    end

    // selected word of the incoming line
    assign word_o = old_word;

endmodule

// File: dcache_pkg.sv
package dcache_pkg;

    ////////////////////////////////////////////////////////////
    // cache geometry
    ////////////////////////////////////////////////////////////

    localparam int addr_w         = 32;
    localparam int word_w         = 32;
    localparam int words_per_line = 8;

    // address splits into tag, index and byte offset
    localparam int offset_w = 5;
    localparam int index_w  = 7;
    localparam int tag_w    = 20;

    localparam int num_sets = 128;
    localparam int num_ways = 2;

    ////////////////////////////////////////////////////////////
    // shared types
    ////////////////////////////////////////////////////////////

    typedef logic [addr_w-1:0]  addr_t;
    typedef logic [word_w-1:0]  word_t;
    typedef logic [3:0]         strb_t;
    typedef logic [index_w-1:0] index_t;
    typedef logic [tag_w-1:0]   tag_t;

    // word 0 sits in the lowest bits
    typedef word_t [words_per_line-1:0] line_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

endpackage

// File: dcache_repl.sv
`timescale 1ns/1ps

module dcache_repl (
    input  logic                           clk,
    input  logic                           rst,
    input  dcache_pkg::index_t             index_i,
    input  logic                           touch_i,
    input  logic                           touch_way_i,
    input  logic                           fill_i,
    input  logic                           set_dirty_i,
    output logic                           victim_way_o,
    output logic                           victim_valid_o,
    output logic                           victim_dirty_o,
    output logic [dcache_pkg::num_ways-1:0] way_valid_o
);

    import dcache_pkg::*;

    // lru bit names the way to evict next
    logic [num_sets-1:0]               lru_q;
    logic [num_sets-1:0][num_ways-1:0] valid_q;
    logic [num_sets-1:0][num_ways-1:0] dirty_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            lru_q   <= '0;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (touch_i) begin
                lru_q[index_i] <= ~touch_way_i;
            end
            if (fill_i) begin
                valid_q[index_i][touch_way_i] <= 1'b1;
                dirty_q[index_i][touch_way_i] <= set_dirty_i;
            end else if (touch_i && set_dirty_i) begin
                // write hit
                dirty_q[index_i][touch_way_i] <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // victim choice
    ////////////////////////////////////////////////////////////

    // an empty way is taken before the lru way
    always_comb begin
        if (!valid_q[index_i][0]) begin
            victim_way_o = 1'b0;
        end else if (!valid_q[index_i][1]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = lru_q[index_i];
        end
    end

    assign victim_valid_o = valid_q[index_i][victim_way_o];
    assign victim_dirty_o = dirty_q[index_i][victim_way_o];
    assign way_valid_o    = valid_q[index_i];

endmodule

// File: dcache_sram.sv
`timescale 1ns/1ps

module dcache_sram #(
    parameter type t_entry = logic,
    parameter int  depth   = dcache_pkg::num_sets
) (
    input  logic               clk,
    input  dcache_pkg::index_t index_i,
    input  logic               we_i,
    input  t_entry             wentry_i,
    output t_entry             rentry_o
);

    // one entry per set
    t_entry mem [depth];

    // single port that reads the old entry on a write to it
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[index_i] <= wentry_i;
        end
        rentry_o <= mem[index_i];
    end

endmodule

// File: dcache_top.f
dcache_pkg.sv
dcache_sram.sv
dcache_repl.sv
dcache_merge.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache.sv

// File: dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic              clk,
    input  logic              rst,
    // cpu side
    input  logic              req_i,
    input  logic              we_i,
    input  dcache_pkg::addr_t addr_i,
    input  dcache_pkg::word_t wdata_i,
    input  dcache_pkg::strb_t wstrb_i,
    output logic              ready_o,
    output logic              resp_valid_o,
    output logic              hit_o,
    output dcache_pkg::word_t rdata_o,
    // memory side
    output logic              mem_ren_o,
    output dcache_pkg::addr_t mem_araddr_o,
    input  logic              mem_rvalid_i,
    input  dcache_pkg::line_t mem_rdata_i,
    output logic              mem_wen_o,
    output dcache_pkg::addr_t mem_awaddr_o,
    output dcache_pkg::line_t mem_wdata_o
);

    import dcache_pkg::*;

    index_t                      ram_index;
    logic [num_ways-1:0]         tag_we;
    tag_entry_t                  tag_wentry;
    tag_entry_t [num_ways-1:0]   tag_rentry;
    logic [num_ways-1:0]         line_we;
    line_t                       line_wentry;
    line_t [num_ways-1:0]        line_rentry;

    logic                touch;
    logic                touch_way;
    logic                fill;
    logic                set_dirty;
    logic                victim_way;
    logic                victim_valid;
    logic                victim_dirty;
    logic [num_ways-1:0] way_valid;

    line_t       merge_line;
    logic [2:0]  merge_word_sel;
    word_t       merge_wdata;
    strb_t       merge_wstrb;
    logic        merge_write;
    word_t       merge_word;
    line_t       merge_line_out;

    dcache_ctrl u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .req_i            (req_i),
        .we_i             (we_i),
        .addr_i           (addr_i),
        .wdata_i          (wdata_i),
        .wstrb_i          (wstrb_i),
        .ready_o          (ready_o),
        .resp_valid_o     (resp_valid_o),
        .hit_o            (hit_o),
        .rdata_o          (rdata_o),
        .mem_ren_o        (mem_ren_o),
        .mem_araddr_o     (mem_araddr_o),
        .mem_rvalid_i     (mem_rvalid_i),
        .mem_rdata_i      (mem_rdata_i),
        .mem_wen_o        (mem_wen_o),
        .mem_awaddr_o     (mem_awaddr_o),
        .mem_wdata_o      (mem_wdata_o),
        .ram_index_o      (ram_index),
        .tag_we_o         (tag_we),
        .tag_wentry_o     (tag_wentry),
        .tag_rentry_i     (tag_rentry),
        .line_we_o        (line_we),
        .line_wentry_o    (line_wentry),
        .line_rentry_i    (line_rentry),
        .touch_o          (touch),
        .touch_way_o      (touch_way),
        .fill_o           (fill),
        .set_dirty_o      (set_dirty),
        .victim_way_i     (victim_way),
        .victim_valid_i   (victim_valid),
        .victim_dirty_i   (victim_dirty),
        .way_valid_i      (way_valid),
        .merge_line_o     (merge_line),
        .merge_word_sel_o (merge_word_sel),
        .merge_wdata_o    (merge_wdata),
        .merge_wstrb_o    (merge_wstrb),
        .merge_write_o    (merge_write),
        .merge_word_i     (merge_word),
        .merge_line_i     (merge_line_out)
    );

    dcache_repl u_repl (
        .clk            (clk),
        .rst            (rst),
        .index_i        (ram_index),
        .touch_i        (touch),
        .touch_way_i    (touch_way),
        .fill_i         (fill),
        .set_dirty_i    (set_dirty),
        .victim_way_o   (victim_way),
        .victim_valid_o (victim_valid),
        .victim_dirty_o (victim_dirty),
        .way_valid_o    (way_valid)
    );

    dcache_merge u_merge (
        .line_i     (merge_line),
        .word_sel_i (merge_word_sel),
        .wdata_i    (merge_wdata),
        .wstrb_i    (merge_wstrb),
        .write_i    (merge_write),
        .word_o     (merge_word),
        .line_o     (merge_line_out)
    );

    // one tag array and one line array per way
    for (genvar w = 0; w < num_ways; w++) begin : g_way
        dcache_sram #(
            .t_entry (tag_entry_t),
            .depth   (num_sets)
        ) u_tag (
            .clk      (clk),
            .index_i  (ram_index),
            .we_i     (tag_we[w]),
            .wentry_i (tag_wentry),
            .rentry_o (tag_rentry[w])
        );

        dcache_sram #(
            .t_entry (line_t),
            .depth   (num_sets)
        ) u_line (
            .clk      (clk),
            .index_i  (ram_index),
            .we_i     (line_we[w]),
            .wentry_i (line_wentry),
            .rentry_o (line_rentry[w])
        );
    end

endmodule

// File: tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

    import dcache_pkg::*;

    localparam int     n_directed     = 12;
    localparam int     n_random       = 400;
    localparam int     timeout_cycles = 40 * (n_directed + n_random);
    localparam tag_t   tag_a          = 20'h00001;
    localparam tag_t   tag_b          = 20'h00002;
    localparam tag_t   tag_c          = 20'h00003;
    localparam index_t set_x          = 7'd3;

    logic  clk          = 1'b0;
    logic  rst          = 1'b1;
    logic  req_i        = 1'b0;
    logic  we_i         = 1'b0;
    addr_t addr_i       = '0;
    word_t wdata_i      = '0;
    strb_t wstrb_i      = '0;
    logic  mem_rvalid_i = 1'b0;
    line_t mem_rdata_i  = '0;
    logic  ready_o;
    logic  resp_valid_o;
    logic  hit_o;
    word_t rdata_o;
    logic  mem_ren_o;
    addr_t mem_araddr_o;
    logic  mem_wen_o;
    addr_t mem_awaddr_o;
    line_t mem_wdata_o;

    int    cycle      = 0;
    logic  pend_we    = 1'b0;
    addr_t pend_addr  = '0;
    word_t exp_rdata  = '0;
    logic  last_hit   = 1'b0;
    int    last_lat   = 0;
    logic  saw_ren    = 1'b0;
    logic  saw_wen    = 1'b0;
    addr_t wen_addr   = '0;
    logic  rd_pending = 1'b0;
    addr_t rd_addr    = '0;
    int    rd_wait    = 0;

    // backing store of the memory model, and the flat reference memory
    line_t mem_lines [addr_t];
    word_t ref_mem [addr_t];

    dcache_top dut (.*);

    always #20 clk = ~clk;

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("Testbench failed");
        $fatal(1);
    endtask

    function automatic word_t fill_word(addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    function automatic addr_t line_addr(addr_t a);
        return {a[addr_w-1:offset_w], {offset_w{1'b0}}};
    endfunction

    function automatic addr_t make_addr(tag_t t, index_t s, logic [2:0] w);
        return {t, s, w, 2'b00};
    endfunction

    function automatic line_t mem_line(addr_t la);
        line_t l;
        if (mem_lines.exists(la)) begin
            return mem_lines[la];
        end
        for (int i = 0; i < words_per_line; i++) begin
            l[i] = fill_word(la + addr_t'(4 * i));
        end
        return l;
    endfunction

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // last value written to a word or else its fill pattern
    function automatic word_t ref_word(addr_t a);
        addr_t wa;
        wa = {a[addr_w-1:2], 2'b00};
        if (ref_mem.exists(wa)) begin
            return ref_mem[wa];
        end
        return fill_word(wa);
    endfunction

    function automatic line_t ref_line(addr_t la);
        line_t l;
        for (int i = 0; i < words_per_line; i++) begin
            l[i] = ref_word(la + addr_t'(4 * i));
        end
        return l;
    endfunction

    task automatic ref_write(input addr_t a, input word_t d, input strb_t s);
        word_t w;
        w = ref_word(a);
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                w[8*b +: 8] = d[8*b +: 8];
            end
        end
        ref_mem[{a[addr_w-1:2], 2'b00}] = w;
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles) begin
            report_failure("timeout: the requests did not complete within the cycle limit");
        end
    end

    // the memory model answers a line read 1 to 6 cycles later
    always @(posedge clk) begin : mem_model
        int n_wait;
        mem_rvalid_i <= 1'b0;
        if (mem_wen_o) begin
            mem_lines[mem_awaddr_o] = mem_wdata_o;
        end
        if (mem_ren_o) begin
            n_wait = $urandom_range(6, 1);
            if (n_wait == 1) begin
                mem_rvalid_i <= 1'b1;
                mem_rdata_i  <= mem_line(mem_araddr_o);
            end else begin
                rd_addr    <= mem_araddr_o;
                rd_wait    <= n_wait - 1;
                rd_pending <= 1'b1;
            end
        end else if (rd_pending) begin
            if (rd_wait <= 1) begin
                mem_rvalid_i <= 1'b1;
                mem_rdata_i  <= mem_line(rd_addr);
                rd_pending   <= 1'b0;
            end else begin
                rd_wait <= rd_wait - 1;
            end
        end
    end

    // compare read data, refill addresses and write-back lines
    always @(posedge clk) begin
        if (!rst) begin
            if (resp_valid_o && !pend_we) begin
                assert (rdata_o == exp_rdata)
                else report_failure($sformatf("FAILED at %0t: rdata_o = %h, expected %h",
                                              $time, rdata_o, exp_rdata));
            end
            if (mem_ren_o) begin
                assert (mem_araddr_o == line_addr(pend_addr))
                else report_failure($sformatf("FAILED at %0t: mem_araddr_o = %h, expected %h",
                                              $time, mem_araddr_o, line_addr(pend_addr)));
            end
            if (mem_wen_o) begin
                assert (mem_wdata_o == ref_line(mem_awaddr_o))
                else report_failure($sformatf("FAILED at %0t: mem_wdata_o = %h, expected %h",
                                              $time, mem_wdata_o, ref_line(mem_awaddr_o)));
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // request driver
    ////////////////////////////////////////////////////////////

    task automatic access(input logic we, input addr_t a, input word_t d, input strb_t s);
        logic done;
        @(posedge clk);
        while (!ready_o) begin
            @(posedge clk);
        end
        pend_we   = we;
        pend_addr = a;
        exp_rdata = ref_word(a);
        if (we) begin
            ref_write(a, d, s);
        end
        saw_ren  = 1'b0;
        saw_wen  = 1'b0;
        last_lat = 0;
        done     = 1'b0;
        req_i   <= 1'b1;
        we_i    <= we;
        addr_i  <= a;
        wdata_i <= d;
        wstrb_i <= s;
        @(posedge clk);
        req_i <= 1'b0;
        while (!done) begin
            @(posedge clk);
            last_lat++;
            assert (!ready_o)
            else report_failure("ready_o was high while a request was still in progress");
            if (mem_ren_o) begin
                saw_ren = 1'b1;
            end
            if (mem_wen_o) begin
                saw_wen  = 1'b1;
                wen_addr = mem_awaddr_o;
            end
            if (resp_valid_o) begin
                done     = 1'b1;
                last_hit = hit_o;
            end
        end
        if (last_hit) begin
            assert (last_lat == 1 && !saw_ren)
            else report_failure("a hit was not answered in the cycle after the request");
        end else begin
            assert (saw_ren && mem_rvalid_i)
            else report_failure("a miss response did not follow a refill read");
        end
    endtask

    task automatic expect_hit(input logic exp);
        assert (last_hit == exp)
        else report_failure($sformatf("FAILED at %0t: hit_o = %0b, expected %0b",
                                      $time, last_hit, exp));
    endtask

    task automatic expect_writeback(input logic exp, input addr_t a);
        assert (saw_wen == exp)
        else report_failure($sformatf("FAILED at %0t: mem_wen_o = %0b, expected %0b",
                                      $time, saw_wen, exp));
        if (exp) begin
            assert (wen_addr == line_addr(a))
            else report_failure($sformatf("FAILED at %0t: mem_awaddr_o = %h, expected %h",
                                          $time, wen_addr, line_addr(a)));
        end
    endtask

    task automatic expect_idle_outputs();
        @(posedge clk);
        assert (ready_o && !resp_valid_o && !hit_o && !mem_ren_o && !mem_wen_o)
        else report_failure("the cache outputs were not in their idle state after reset");
    endtask

    initial begin
        tag_t       t;
        index_t     s;
        logic [2:0] w;
        logic       we;
        void'($urandom(83));
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        expect_idle_outputs();

        // cold miss, then hits and byte-select writes on the same line
        access(1'b0, make_addr(tag_a, set_x, 3'd2), '0, '0);
        expect_hit(1'b0);
        expect_writeback(1'b0, '0);
        access(1'b0, make_addr(tag_a, set_x, 3'd5), '0, '0);
        expect_hit(1'b1);
        access(1'b1, make_addr(tag_a, set_x, 3'd5), 32'hcafe_f00d, 4'b1111);
        expect_hit(1'b1);
        access(1'b0, make_addr(tag_a, set_x, 3'd5), '0, '0);
        access(1'b1, make_addr(tag_a, set_x, 3'd1), 32'h1122_3344, 4'b0101);
        expect_hit(1'b1);
        access(1'b0, make_addr(tag_a, set_x, 3'd1), '0, '0);
        // partial write miss fills the second way
        access(1'b1, make_addr(tag_b, set_x, 3'd6), 32'hdead_beef, 4'b1000);
        expect_hit(1'b0);
        access(1'b0, make_addr(tag_b, set_x, 3'd6), '0, '0);
        expect_hit(1'b1);

        // a touched last makes c evict dirty b
        access(1'b0, make_addr(tag_a, set_x, 3'd0), '0, '0);
        expect_hit(1'b1);
        access(1'b0, make_addr(tag_c, set_x, 3'd3), '0, '0);
        expect_hit(1'b0);
        expect_writeback(1'b1, make_addr(tag_b, set_x, 3'd0));
        access(1'b0, make_addr(tag_a, set_x, 3'd4), '0, '0);
        expect_hit(1'b1);
        // b comes back in place of clean c
        access(1'b0, make_addr(tag_b, set_x, 3'd6), '0, '0);
        expect_hit(1'b0);
        expect_writeback(1'b0, '0);

        // random mix over three sets and four tags
        for (int i = 0; i < n_random; i++) begin
            t  = tag_t'($urandom_range(4, 1));
            s  = index_t'($urandom_range(5, 3));
            w  = 3'($urandom());
            we = 1'($urandom());
            access(we, make_addr(t, s, w), $urandom(), strb_t'($urandom()));
        end

        $display("Testbench passed");
        $finish;
    end

endmodule
